//--- logic/i2c_pkg.sv
package i2c_pkg;

  // bit counts of one transaction
  localparam int HDR_BITS  = 13;
  localparam int DATA_BITS = 8;
  localparam int TURN_BITS = 2;
  localparam int MEM_AW    = 5;

  // address this target answers to
  localparam logic [6:0] DEV_ADDR = 7'h2a;

  typedef enum logic [2:0] {
    st_idle     = 3'd0,
    st_hdr_rx   = 3'd1,
    st_hdr_ack  = 3'd2,
    st_turn     = 3'd3,
    st_data     = 3'd4,
    st_data_end = 3'd5,
    st_hold     = 3'd6
  } i2c_state_e;

  // header arrives lsb first, so dir ends up in bit 0
  typedef struct packed {
    logic [6:0]        dev_addr;
    logic [MEM_AW-1:0] mem_addr;
    logic              dir;
  } i2c_hdr_s;

  // a received byte lands in the top bits after eight shifts
  typedef struct packed {
    logic [DATA_BITS-1:0]          rx_byte;
    logic [HDR_BITS-DATA_BITS-1:0] pad;
  } i2c_dat_s;

  typedef union packed {
    i2c_hdr_s hdr;
    i2c_dat_s dat;
  } i2c_frame_u;

endpackage

//--- logic/i2c_bus_cond.sv
`timescale 1ns/1ps

module i2c_bus_cond (
  input  logic rst,
  input  logic scl_i,
  input  logic sda_i,
  output logic start_det_o,
  output logic stop_det_o
);

  logic start_q;
  logic start_clr_q;
  logic stop_q;
  logic stop_clr_q;
  logic start_clr;
  logic stop_clr;

  assign start_clr = ~rst | start_clr_q;
  assign stop_clr  = ~rst | stop_clr_q;

  // start: sda falls while scl is high
  always_ff @(negedge sda_i or posedge start_clr) begin
    if (start_clr) begin
      start_q <= 1'b0;
    end else begin
      start_q <= scl_i;
    end
  end

  // stop: sda rises while scl is high
  always_ff @(posedge sda_i or posedge stop_clr) begin
    if (stop_clr) begin
      stop_q <= 1'b0;
    end else begin
      stop_q <= scl_i;
    end
  end

  // one scl later the flag is knocked down again
  always_ff @(posedge scl_i or negedge rst) begin
    if (!rst) begin
      start_clr_q <= 1'b0;
      stop_clr_q  <= 1'b0;
    end else begin
      start_clr_q <= start_q;
      stop_clr_q  <= stop_q;
    end
  end

  assign start_det_o = start_q;
  assign stop_det_o  = stop_q;

endmodule

//--- logic/i2c_shift_unit.sv
`timescale 1ns/1ps

module i2c_shift_unit (
  input  logic                            rst,
  input  logic                            scl_i,
  input  logic                            sda_i,
  input  logic                            rx_shift_i,
  input  logic                            tx_load_i,
  input  logic                            tx_shift_i,
  input  logic [i2c_pkg::DATA_BITS-1:0]   tx_data_i,
  output i2c_pkg::i2c_frame_u             frame_o,
  output logic                            tx_bit_o
);

  import i2c_pkg::*;

  i2c_frame_u           frame_q;
  logic [DATA_BITS-1:0] tx_q;

  // new bits enter at the top, so the first bit ends at bit 0
  always_ff @(posedge scl_i or negedge rst) begin
    if (!rst) begin
      frame_q <= '0;
    end else if (rx_shift_i) begin
      frame_q <= {sda_i, frame_q[HDR_BITS-1:1]};
    end
  end

  // transmit byte goes out lsb first
  always_ff @(posedge scl_i or negedge rst) begin
    if (!rst) begin
      tx_q <= '0;
    end else if (tx_load_i) begin
      tx_q <= tx_data_i;
    end else if (tx_shift_i) begin
      tx_q <= tx_q >> 1;
    end
  end

  assign frame_o  = frame_q;
  assign tx_bit_o = tx_q[0];

endmodule

//--- logic/i2c_regfile.sv
`timescale 1ns/1ps

module i2c_regfile (
  input  logic                          rst,
  input  logic                          scl_i,
  input  logic                          wr_en_i,
  input  logic [i2c_pkg::MEM_AW-1:0]    addr_i,
  input  logic [i2c_pkg::DATA_BITS-1:0] wr_data_i,
  output logic [i2c_pkg::DATA_BITS-1:0] rd_data_o
);

  import i2c_pkg::*;

  logic [DATA_BITS-1:0] mem [2**MEM_AW];

  always_ff @(posedge scl_i or negedge rst) begin
    if (!rst) begin
      for (int i = 0; i < 2**MEM_AW; i++) begin
        mem[i] <= '0;
      end
    end else if (wr_en_i) begin
      mem[addr_i] <= wr_data_i;
    end
  end

  assign rd_data_o = mem[addr_i];

endmodule

//--- logic/i2c_slave_ctrl.sv
`timescale 1ns/1ps

module i2c_slave_ctrl (
  input  logic                        rst,
  input  logic                        scl_i,
  input  logic                        start_det_i,
  input  logic                        stop_det_i,
  input  i2c_pkg::i2c_frame_u         frame_i,
  input  logic                        tx_bit_i,
  output logic                        rx_shift_o,
  output logic                        tx_load_o,
  output logic                        tx_shift_o,
  output logic                        wr_en_o,
  output logic [i2c_pkg::MEM_AW-1:0]  mem_addr_o,
  output logic                        sda_o,
  output logic                        sda_t
);

  import i2c_pkg::*;

  i2c_state_e        state_q;
  i2c_state_e        state_d;
  logic [3:0]        bit_cnt;
  logic              dir_q;
  logic [MEM_AW-1:0] mem_addr_q;
  logic              wr_en_q;
  logic              state_rst_n;
  logic              dev_match;
  logic              hdr_last;
  logic              turn_last;
  logic              data_last;
  logic              counting;
  logic              ack_hdr;
  logic              ack_wr;
  logic              drv_rd;

  assign dev_match = (frame_i.hdr.dev_addr == DEV_ADDR);
  assign hdr_last  = (bit_cnt == 4'(HDR_BITS - 1));
  assign turn_last = (bit_cnt == 4'(TURN_BITS - 1));
  assign data_last = (bit_cnt == 4'(DATA_BITS - 1));
  assign counting  = (state_q == st_hdr_rx) || (state_q == st_turn) || (state_q == st_data);

  // in hold a stop drops the machine straight back to idle
  assign state_rst_n = (state_q == st_hold) ? (rst & ~stop_det_i) : rst;

  always_ff @(posedge scl_i or negedge state_rst_n) begin
    if (!state_rst_n) begin
      state_q <= st_idle;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      st_idle:     if (start_det_i) state_d = st_hdr_rx;
      st_hdr_rx:   if (hdr_last) state_d = st_hdr_ack;
      st_hdr_ack: begin
        if (!dev_match) begin
          state_d = st_idle;
        end else begin
          state_d = frame_i.hdr.dir ? st_data : st_turn;
        end
      end
      st_turn:     if (turn_last) state_d = st_data;
      st_data:     if (data_last) state_d = st_data_end;
      st_data_end: state_d = st_hold;
      st_hold:     state_d = st_hold;
      default:     state_d = st_idle;
    endcase
  end

  // counter restarts on every phase change
  always_ff @(posedge scl_i or negedge rst) begin
    if (!rst) begin
      bit_cnt <= '0;
    end else if (!counting || state_d != state_q) begin
      bit_cnt <= '0;
    end else begin
      bit_cnt <= bit_cnt + 4'd1;
    end
  end

  always_ff @(posedge scl_i or negedge rst) begin
    if (!rst) begin
      dir_q      <= 1'b0;
      mem_addr_q <= '0;
      wr_en_q    <= 1'b0;
    end else begin
      if (state_q == st_hdr_ack) begin
        dir_q      <= frame_i.hdr.dir;
        mem_addr_q <= frame_i.hdr.mem_addr;
      end
      // write lands one edge after the closing ack
      wr_en_q <= (state_q == st_data_end) && dir_q;
    end
  end

  assign rx_shift_o = (state_q == st_hdr_rx) || ((state_q == st_data) && dir_q);
  assign tx_load_o  = (state_q == st_turn) && turn_last;
  assign tx_shift_o = (state_q == st_data) && !dir_q;
  assign wr_en_o    = wr_en_q;
  assign mem_addr_o = mem_addr_q;

  // open drain: pull low for acks, follow tx bit on reads
  assign ack_hdr = (state_q == st_hdr_ack) && dev_match;
  assign ack_wr  = (state_q == st_data_end) && dir_q;
  assign drv_rd  = (state_q == st_data) && !dir_q;

  assign sda_t = ~(ack_hdr | ack_wr | drv_rd);
  assign sda_o = drv_rd ? tx_bit_i : ~(ack_hdr | ack_wr);

endmodule

//--- logic/i2c_mem_target.sv
`timescale 1ns/1ps

module i2c_mem_target (
  input  logic rst,
  input  logic scl_i,
  input  logic sda_i,
  output logic sda_o,
  output logic sda_t
);

  import i2c_pkg::*;

  logic                 start_det;
  logic                 stop_det;
  logic                 rx_shift;
  logic                 tx_load;
  logic                 tx_shift;
  logic                 wr_en;
  logic                 tx_bit;
  logic [MEM_AW-1:0]    mem_addr;
  logic [DATA_BITS-1:0] rd_data;
  i2c_frame_u           frame;

  i2c_bus_cond i2c_bus_cond_i (
    .rst         (rst),
    .scl_i       (scl_i),
    .sda_i       (sda_i),
    .start_det_o (start_det),
    .stop_det_o  (stop_det)
  );

  i2c_slave_ctrl i2c_slave_ctrl_i (
    .rst         (rst),
    .scl_i       (scl_i),
    .start_det_i (start_det),
    .stop_det_i  (stop_det),
    .frame_i     (frame),
    .tx_bit_i    (tx_bit),
    .rx_shift_o  (rx_shift),
    .tx_load_o   (tx_load),
    .tx_shift_o  (tx_shift),
    .wr_en_o     (wr_en),
    .mem_addr_o  (mem_addr),
    .sda_o       (sda_o),
    .sda_t       (sda_t)
  );

  i2c_shift_unit i2c_shift_unit_i (
    .rst        (rst),
    .scl_i      (scl_i),
    .sda_i      (sda_i),
    .rx_shift_i (rx_shift),
    .tx_load_i  (tx_load),
    .tx_shift_i (tx_shift),
    .tx_data_i  (rd_data),
    .frame_o    (frame),
    .tx_bit_o   (tx_bit)
  );

  // write data is the byte view of the frame word
  i2c_regfile i2c_regfile_i (
    .rst       (rst),
    .scl_i     (scl_i),
    .wr_en_i   (wr_en),
    .addr_i    (mem_addr),
    .wr_data_i (frame.dat.rx_byte),
    .rd_data_o (rd_data)
  );

endmodule

//--- verification/tb_i2c_mem_target.sv
`timescale 1ns/1ps

module tb_i2c_mem_target;

  import i2c_pkg::*;

  logic              tb_clk = 1'b0;
  logic              rst = 1'b1;
  logic              scl = 1'b1;
  logic              sda_m = 1'b1;
  logic              sda_o;
  logic              sda_t;
  logic              sda_line;
  logic              quiet = 1'b0;
  logic              ack_chk = 1'b0;
  logic              ack_exp = 1'b0;
  logic              ack_line = 1'b1;
  logic              byte_chk = 1'b0;
  logic [7:0]        rd_byte = '0;
  logic [7:0]        rd_exp = '0;
  logic [7:0]        ref_mem [32];
  logic [MEM_AW-1:0] wr_addrs [$];

  i2c_mem_target i2c_mem_target_i (
    .rst   (rst),
    .scl_i (scl),
    .sda_i (sda_line),
    .sda_o (sda_o),
    .sda_t (sda_t)
  );

  // wired-AND of master and target where the target only pulls low
  assign sda_line = sda_m & (sda_t | sda_o);

  always #10 tb_clk = ~tb_clk;

  function automatic void report_mismatch(string name, logic [7:0] got, logic [7:0] exp);
    $display("FAIL %s got %h expected %h", name, got, exp);
    $display("RESULT: FAIL");
  endfunction

  a_reset_release: assert property (@(posedge tb_clk) !rst |-> sda_t)
    else begin
      report_mismatch("sda_t", {7'd0, $sampled(sda_t)}, 8'h01);
      $fatal(1, "sda not released in reset");
    end

  a_quiet: assert property (@(posedge tb_clk) quiet |-> sda_t)
    else begin
      report_mismatch("sda_t", {7'd0, $sampled(sda_t)}, 8'h01);
      $fatal(1, "target drove sda while not addressed");
    end

  a_ack: assert property (@(posedge tb_clk) ack_chk |-> (ack_line == !ack_exp))
    else begin
      report_mismatch("ack_line", {7'd0, ack_line}, {7'd0, !ack_exp});
      $fatal(1, "wrong acknowledge");
    end

  a_read_byte: assert property (@(posedge tb_clk) byte_chk |-> (rd_byte == rd_exp))
    else begin
      report_mismatch("rd_byte", rd_byte, rd_exp);
      $fatal(1, "wrong read data");
    end

  // scl low, sda change, scl high, hold; line sampled just before scl rises
  task automatic bus_clock(input logic b, output logic s);
    @(posedge tb_clk);
    scl <= 1'b0;
    @(posedge tb_clk);
    sda_m <= b;
    @(posedge tb_clk);
    s = sda_line;
    scl <= 1'b1;
    @(posedge tb_clk);
  endtask

  task automatic wait_bus_free();
    int n;
    n = 0;
    while (sda_line !== 1'b1 || scl !== 1'b1) begin
      if (n >= 40) begin
        $display("bus phase timed out");
        $display("RESULT: FAIL");
        $fatal(1, "bus never became free");
      end else begin
        n++;
        @(posedge tb_clk);
      end
    end
  endtask

  task automatic send_start();
    @(posedge tb_clk);
    sda_m <= 1'b0;
    @(posedge tb_clk);
  endtask

  task automatic send_stop();
    @(posedge tb_clk);
    scl <= 1'b0;
    @(posedge tb_clk);
    sda_m <= 1'b0;
    @(posedge tb_clk);
    scl <= 1'b1;
    @(posedge tb_clk);
    sda_m <= 1'b1;
    @(posedge tb_clk);
  endtask

  task automatic check_ack(input logic s, input logic exp);
    ack_line <= s;
    ack_exp  <= exp;
    ack_chk  <= 1'b1;
    @(posedge tb_clk);
    ack_chk <= 1'b0;
  endtask

  task automatic check_byte(input logic [7:0] got, input logic [7:0] exp);
    rd_byte  <= got;
    rd_exp   <= exp;
    byte_chk <= 1'b1;
    @(posedge tb_clk);
    byte_chk <= 1'b0;
  endtask

  task automatic run_transfer(input logic dir, input logic [6:0] dev,
                              input logic [MEM_AW-1:0] addr, input logic [7:0] wdata,
                              output logic [7:0] rdata);
    logic [HDR_BITS-1:0] hdr;
    logic                s;
    logic                hit;
    hdr   = {dev, addr, dir};
    hit   = (dev == DEV_ADDR);
    rdata = '0;
    quiet <= !hit;
    wait_bus_free();
    send_start();
    // extra clock that takes the target out of idle
    bus_clock(1'b0, s);
    for (int i = 0; i < HDR_BITS; i++) begin
      bus_clock(hdr[i], s);
    end
    bus_clock(1'b1, s);
    check_ack(s, hit);
    if (!dir) begin
      for (int i = 0; i < TURN_BITS; i++) begin
        bus_clock(1'b1, s);
      end
      for (int i = 0; i < DATA_BITS; i++) begin
        bus_clock(1'b1, s);
        rdata[i] = s;
      end
    end else begin
      for (int i = 0; i < DATA_BITS; i++) begin
        bus_clock(wdata[i], s);
      end
    end
    bus_clock(1'b1, s);
    check_ack(s, hit && dir);
    send_stop();
    quiet <= 1'b1;
  endtask

  task automatic write_byte(input logic [MEM_AW-1:0] addr, input logic [7:0] data);
    logic [7:0] unused;
    run_transfer(1'b1, DEV_ADDR, addr, data, unused);
    ref_mem[addr] = data;
    wr_addrs.push_back(addr);
  endtask

  task automatic read_check(input logic [MEM_AW-1:0] addr);
    logic [7:0] got;
    run_transfer(1'b0, DEV_ADDR, addr, 8'h00, got);
    check_byte(got, ref_mem[addr]);
  endtask

  // reset lands while the target holds the header ack low
  task automatic reset_mid_transfer(input logic [MEM_AW-1:0] addr);
    logic [HDR_BITS-1:0] hdr;
    logic                s;
    hdr = {DEV_ADDR, addr, 1'b1};
    quiet <= 1'b0;
    wait_bus_free();
    send_start();
    bus_clock(1'b0, s);
    for (int i = 0; i < HDR_BITS; i++) begin
      bus_clock(hdr[i], s);
    end
    @(posedge tb_clk);
    scl   <= 1'b0;
    sda_m <= 1'b1;
    @(posedge tb_clk);
    rst <= 1'b0;
    repeat (2) @(posedge tb_clk);
    rst <= 1'b1;
    send_stop();
    quiet <= 1'b1;
    for (int i = 0; i < 32; i++) begin
      ref_mem[i] = '0;
    end
  endtask

  initial begin
    logic [31:0]       rnd;
    logic [MEM_AW-1:0] addr;
    logic [7:0]        data;
    logic [6:0]        dev;
    logic [7:0]        got;
    rnd = $urandom(32'h438f_ebd8);
    for (int i = 0; i < 32; i++) begin
      ref_mem[i] = '0;
    end
    @(posedge tb_clk);
    rst <= 1'b0;
    repeat (2) @(posedge tb_clk);
    rst   <= 1'b1;
    quiet <= 1'b1;
    repeat (4) @(posedge tb_clk);
    rnd = $urandom();
    read_check(rnd[4:0]);
    // a write to a foreign device address leaves memory unchanged
    rnd = $urandom();
    run_transfer(1'b1, DEV_ADDR ^ 7'h01, rnd[4:0], rnd[12:5], got);
    read_check(rnd[4:0]);
    for (int n = 0; n < 12; n++) begin
      rnd  = $urandom();
      addr = rnd[4:0];
      data = rnd[12:5];
      if (rnd[14:13] == 2'd0) begin
        // foreign device address leaves memory unchanged
        dev = rnd[21:15];
        if (dev == DEV_ADDR) dev = dev ^ 7'h01;
        run_transfer(rnd[22], dev, addr, data, got);
      end else begin
        write_byte(addr, data);
      end
      read_check(addr);
    end
    rnd = $urandom();
    reset_mid_transfer(rnd[4:0]);
    foreach (wr_addrs[i]) begin
      read_check(wr_addrs[i]);
    end
    $display("RESULT: PASS");
    $finish;
  end

endmodule

//--- all.f
logic/i2c_pkg.sv
logic/i2c_bus_cond.sv
logic/i2c_shift_unit.sv
logic/i2c_regfile.sv
logic/i2c_slave_ctrl.sv
logic/i2c_mem_target.sv
verification/tb_i2c_mem_target.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module tb_i2c_mem_target \
  -f all.f \
  -o sim_tb

status=0
./obj_dir/sim_tb > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "RESULT: FAIL" sim.log; then
  echo "simulation reported failure"
  exit 1
fi
if [ "$status" -ne 0 ] || ! grep -q "RESULT: PASS" sim.log; then
  echo "simulation did not finish cleanly"
  exit 1
fi
echo "simulation passed"
